//--- videoPkg.sv
// shared constants and types for the video output stage; referenced by scoped names only
package videoPkg;

	// ------------------------------
	// raster geometry
	// ------------------------------

	// horizontal sizes in clocks, order is active, front, sync, back
	localparam int cHActive = 16;
	localparam int cHFront  = 2;
	localparam int cHSync   = 3;
	localparam int cHBack   = 4;
	localparam int cHTotal  = cHActive + cHFront + cHSync + cHBack;

	// vertical sizes in lines
	localparam int cVActive = 4;
	localparam int cVFront  = 1;
	localparam int cVSync   = 2;
	localparam int cVBack   = 2;
	localparam int cVTotal  = cVActive + cVFront + cVSync + cVBack;

	// ------------------------------
	// pixel buffer
	// ------------------------------

	// one yuyv word per clock
	localparam int cPixelWidth   = 16;
	// depth must be a power of two, pointers wrap naturally
	localparam int cFifoDepth    = 32;
	// fill count needs one bit more than the pointers
	localparam int cLevelWidth   = 6;
	// pixels to hold before the raster leaves reset
	localparam int cPrefillLevel = 8;

	// ------------------------------
	// wishbone word addresses
	// ------------------------------
	localparam logic [1:0] cAdrCtrl   = 2'd0;
	localparam logic [1:0] cAdrStatus = 2'd1;
	localparam logic [1:0] cAdrLevel  = 2'd2;

	// start-up control states, also readable in STATUS[2:1]
	typedef enum logic [1:0]
	{
		stIdle  = 2'd0,
		stFill  = 2'd1,
		stRun   = 2'd2,
		stUnder = 2'd3
	} tStartState;

endpackage

//--- pixelFifo.sv
// single clock pixel line buffer between the camera side and the display raster
`timescale 1ns/1ps

module pixelFifo
(
	input  logic                               iVCLK,
	input  logic                               iVRST,
	input  logic                               i_flush,
	input  logic [videoPkg::cPixelWidth-1:0]   i_wrData,
	input  logic                               i_wrEn,
	input  logic                               i_rdEn,
	output logic [videoPkg::cPixelWidth-1:0]   o_rdData,
	output logic [videoPkg::cLevelWidth-1:0]   o_level,
	output logic                               o_full,
	output logic                               o_underflow
);

	// pixel storage
	logic [videoPkg::cPixelWidth-1:0] mem [videoPkg::cFifoDepth];
	logic [$clog2(videoPkg::cFifoDepth)-1:0] wrPtr;
	logic [$clog2(videoPkg::cFifoDepth)-1:0] rdPtr;
	logic [videoPkg::cLevelWidth-1:0] count;
	logic empty;
	logic wrOk;
	logic rdOk;

	// flags straight from the count
	assign empty  = (count == '0);
	assign o_full = (int'(count) == videoPkg::cFifoDepth);
	assign wrOk   = i_wrEn & ~o_full;
	assign rdOk   = i_rdEn & ~empty;
	assign o_level = count;

	// a write while full is simply dropped
	always_ff @(posedge iVCLK)
	begin
		if (wrOk)
		begin
			mem[wrPtr] <= i_wrData;
		end
	end

	// registered read data lines up with the registered data-enable
	always_ff @(posedge iVCLK)
	begin
		if (i_rdEn)
		begin
			o_rdData <= rdOk ? mem[rdPtr] : '0;
		end
	end

	// pointers, count and underflow pulse
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || i_flush)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			o_underflow <= 1'b0;
		end
		else
		begin
			// pop refused on empty
			o_underflow <= i_rdEn & empty;
			if (wrOk)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (rdOk)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// simultaneous push and pop keeps the count
			case ({wrOk, rdOk})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- videoTimingGen.sv
// raster counters for the display side; early fetch strobe plus registered sync and data-enable
`timescale 1ns/1ps

module videoTimingGen
(
	input  logic iVCLK,
	input  logic iVRST,
	input  logic i_hold,
	output logic o_fetch,
	output logic o_hSync,
	output logic o_vSync,
	output logic o_de
);

	logic [$clog2(videoPkg::cHTotal)-1:0] hCount;
	logic [$clog2(videoPkg::cVTotal)-1:0] vCount;
	logic hActive;
	logic vActive;
	logic hSyncNow;
	logic vSyncNow;
	logic hLast;
	logic vLast;

	// ------------------------------
	// decode of the current counts
	// ------------------------------

	// active area sits at the start of line and frame
	assign hActive = (int'(hCount) < videoPkg::cHActive);
	assign vActive = (int'(vCount) < videoPkg::cVActive);

	// sync after the front porch
	assign hSyncNow = (int'(hCount) >= videoPkg::cHActive + videoPkg::cHFront) &&
		(int'(hCount) < videoPkg::cHActive + videoPkg::cHFront + videoPkg::cHSync);
	assign vSyncNow = (int'(vCount) >= videoPkg::cVActive + videoPkg::cVFront) &&
		(int'(vCount) < videoPkg::cVActive + videoPkg::cVFront + videoPkg::cVSync);

	assign hLast = (int'(hCount) == videoPkg::cHTotal - 1);
	assign vLast = (int'(vCount) == videoPkg::cVTotal - 1);

	// one clock ahead of o_de, buffer pops on this
	assign o_fetch = ~i_hold & hActive & vActive;

	// ------------------------------
	// counters and output registers
	// ------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || i_hold)
		begin
			// parked at 0,0, first clock after release is the first active pixel
			hCount  <= '0;
			vCount  <= '0;
			o_hSync <= 1'b0;
			o_vSync <= 1'b0;
			o_de    <= 1'b0;
		end
		else
		begin
			if (hLast)
			begin
				hCount <= '0;
				// vertical steps once per line
				vCount <= vLast ? '0 : vCount + 1'b1;
			end
			else
			begin
				hCount <= hCount + 1'b1;
			end
			// same decode as fetch, one clock later
			o_hSync <= hSyncNow;
			o_vSync <= vSyncNow;
			o_de    <= hActive & vActive;
		end
	end

endmodule

//--- videoStartCtrl.sv
// start-up FSM; keeps the raster in reset until the buffer is prefilled and handles underflow
`timescale 1ns/1ps

module videoStartCtrl
(
	input  logic                             iVCLK,
	input  logic                             iVRST,
	input  logic                             i_enable,
	input  logic [videoPkg::cLevelWidth-1:0] i_level,
	input  logic                             i_underflow,
	output videoPkg::tStartState             o_state,
	output logic                             o_hold,
	output logic                             o_flush,
	output logic                             o_underflowSet
);

	videoPkg::tStartState state;
	videoPkg::tStartState nextState;
	logic prefilled;

	// enough pixels stored to survive the first lines
	assign prefilled = (int'(i_level) >= videoPkg::cPrefillLevel);

	// next state
	always_comb
	begin
		nextState = state;
		case (state)
			videoPkg::stIdle:
			begin
				nextState = videoPkg::stFill;
			end
			videoPkg::stFill:
			begin
				if (prefilled)
				begin
					nextState = videoPkg::stRun;
				end
			end
			videoPkg::stRun:
			begin
				if (i_underflow)
				begin
					nextState = videoPkg::stUnder;
				end
			end
			default:
			begin
				// one clock in stUnder, then refill
				nextState = videoPkg::stFill;
			end
		endcase
		// enable low wins from any state
		if (!i_enable)
		begin
			nextState = videoPkg::stIdle;
		end
	end

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			state <= videoPkg::stIdle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// outputs decoded from the state register
	assign o_state = state;
	// raster runs only in stRun
	assign o_hold = (state != videoPkg::stRun);
	assign o_flush = (state == videoPkg::stIdle);
	// stUnder lasts a single clock, so this is a pulse
	assign o_underflowSet = (state == videoPkg::stUnder);

endmodule

//--- videoOutFormat.sv
// last register stage before the transmitter pins; blanks data and swaps the yuyv bytes
`timescale 1ns/1ps

module videoOutFormat
(
	input  logic                             iVCLK,
	input  logic                             iVRST,
	input  logic                             i_hSync,
	input  logic                             i_vSync,
	input  logic                             i_de,
	input  logic [videoPkg::cPixelWidth-1:0] i_pixel,
	output logic                             o_videoHs,
	output logic                             o_videoVs,
	output logic                             o_videoDe,
	output logic [videoPkg::cPixelWidth-1:0] o_videoData
);

	logic [videoPkg::cPixelWidth-1:0] swapped;

	// transmitter wants Y in the upper byte, chroma in the lower
	assign swapped = {i_pixel[7:0], i_pixel[15:8]};

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_videoHs   <= 1'b0;
			o_videoVs   <= 1'b0;
			o_videoDe   <= 1'b0;
			o_videoData <= '0;
		end
		else
		begin
			// sync and de take the same stage as data
			o_videoHs <= i_hSync;
			o_videoVs <= i_vSync;
			o_videoDe <= i_de;
			// zero outside the active area
			o_videoData <= i_de ? swapped : '0;
		end
	end

endmodule

//--- videoWbRegs.sv
// wishbone classic slave with the enable bit, sticky underflow flag, state and fill level
`timescale 1ns/1ps

module videoWbRegs
(
	input  logic                             iVCLK,
	input  logic                             iVRST,
	input  logic                             i_wbCyc,
	input  logic                             i_wbStb,
	input  logic                             i_wbWe,
	input  logic [1:0]                       i_wbAdr,
	input  logic [31:0]                      i_wbDatW,
	output logic [31:0]                      o_wbDatR,
	output logic                             o_wbAck,
	input  videoPkg::tStartState             i_state,
	input  logic                             i_full,
	input  logic [videoPkg::cLevelWidth-1:0] i_level,
	input  logic                             i_underflowSet,
	output logic                             o_enable
);

	logic request;
	logic wrCtrl;
	logic wrStatus;
	logic underflowFlag;
	logic [31:0] readMux;

	// new request, ack low between transfers
	assign request  = i_wbCyc & i_wbStb & ~o_wbAck;
	assign wrCtrl   = request & i_wbWe & (i_wbAdr == videoPkg::cAdrCtrl);
	assign wrStatus = request & i_wbWe & (i_wbAdr == videoPkg::cAdrStatus);

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb
	begin
		case (i_wbAdr)
			videoPkg::cAdrCtrl:   readMux = {31'd0, o_enable};
			// full, state, sticky flag
			videoPkg::cAdrStatus: readMux = {28'd0, i_full, i_state, underflowFlag};
			videoPkg::cAdrLevel:  readMux = {{(32 - videoPkg::cLevelWidth){1'b0}}, i_level};
			default:              readMux = '0;
		endcase
	end

	// ack, read data and registers
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_wbAck       <= 1'b0;
			o_wbDatR      <= '0;
			o_enable      <= 1'b0;
			underflowFlag <= 1'b0;
		end
		else
		begin
			// single clock ack, data valid with it
			o_wbAck  <= request;
			o_wbDatR <= (request & ~i_wbWe) ? readMux : '0;
			if (wrCtrl)
			begin
				o_enable <= i_wbDatW[0];
			end
			// set beats write-one-to-clear
			if (i_underflowSet)
			begin
				underflowFlag <= 1'b1;
			end
			else if (wrStatus && i_wbDatW[0])
			begin
				underflowFlag <= 1'b0;
			end
		end
	end

endmodule

//--- videoPostProcess.sv
// top of the video output stage; buffer, raster timing, start-up control, formatter, registers
`timescale 1ns/1ps

module videoPostProcess
(
	input  logic                             iVCLK,
	input  logic                             iVRST,
	// pixel source
	input  logic [videoPkg::cPixelWidth-1:0] i_pixelData,
	input  logic                             i_pixelValid,
	output logic                             o_pixelFull,
	// wishbone
	input  logic                             i_wbCyc,
	input  logic                             i_wbStb,
	input  logic                             i_wbWe,
	input  logic [1:0]                       i_wbAdr,
	input  logic [31:0]                      i_wbDatW,
	output logic [31:0]                      o_wbDatR,
	output logic                             o_wbAck,
	// transmitter
	output logic                             o_videoHs,
	output logic                             o_videoVs,
	output logic                             o_videoDe,
	output logic [videoPkg::cPixelWidth-1:0] o_videoData
);

	logic [videoPkg::cPixelWidth-1:0] rdData;
	logic [videoPkg::cLevelWidth-1:0] level;
	logic underflow;
	logic fetch;
	logic hSync;
	logic vSync;
	logic de;
	logic hold;
	logic flush;
	logic underflowSet;
	logic enable;
	videoPkg::tStartState state;

	// ------------------------------
	// line buffer
	// ------------------------------
	pixelFifo pixelFifo_i
	(
		.iVCLK(iVCLK),           .iVRST(iVRST),
		.i_flush(flush),
		.i_wrData(i_pixelData),  .i_wrEn(i_pixelValid),
		.i_rdEn(fetch),          .o_rdData(rdData),
		.o_level(level),         .o_full(o_pixelFull),
		.o_underflow(underflow)
	);

	// raster, parked while hold is high
	videoTimingGen videoTimingGen_i
	(
		.iVCLK(iVCLK),           .iVRST(iVRST),
		.i_hold(hold),           .o_fetch(fetch),
		.o_hSync(hSync),         .o_vSync(vSync),
		.o_de(de)
	);

	// prefill and underflow handling
	videoStartCtrl videoStartCtrl_i
	(
		.iVCLK(iVCLK),           .iVRST(iVRST),
		.i_enable(enable),       .i_level(level),
		.i_underflow(underflow), .o_state(state),
		.o_hold(hold),           .o_flush(flush),
		.o_underflowSet(underflowSet)
	);

	// ------------------------------
	// output stage and registers
	// ------------------------------
	videoOutFormat videoOutFormat_i
	(
		.iVCLK(iVCLK),           .iVRST(iVRST),
		.i_hSync(hSync),         .i_vSync(vSync),
		.i_de(de),               .i_pixel(rdData),
		.o_videoHs(o_videoHs),   .o_videoVs(o_videoVs),
		.o_videoDe(o_videoDe),   .o_videoData(o_videoData)
	);

	videoWbRegs videoWbRegs_i
	(
		.iVCLK(iVCLK),           .iVRST(iVRST),
		.i_wbCyc(i_wbCyc),       .i_wbStb(i_wbStb),
		.i_wbWe(i_wbWe),         .i_wbAdr(i_wbAdr),
		.i_wbDatW(i_wbDatW),     .o_wbDatR(o_wbDatR),
		.o_wbAck(o_wbAck),       .i_state(state),
		.i_full(o_pixelFull),    .i_level(level),
		.i_underflowSet(underflowSet),
		.o_enable(enable)
	);

endmodule

//--- videoPostProcessTb.sv
// testbench for the video output stage; compiled from files.f and run by run.sh
`timescale 1ns/1ps

module videoPostProcessTb;

	localparam int cWaitLimit = 3000;
	localparam int cPollLimit = 60;

	logic        iVCLK;
	logic        iVRST;
	logic [15:0] i_pixelData;
	logic        i_pixelValid;
	logic        o_pixelFull;
	logic        i_wbCyc;
	logic        i_wbStb;
	logic        i_wbWe;
	logic [1:0]  i_wbAdr;
	logic [31:0] i_wbDatW;
	logic [31:0] o_wbDatR;
	logic        o_wbAck;
	logic        o_videoHs;
	logic        o_videoVs;
	logic        o_videoDe;
	logic [15:0] o_videoData;

	int valueErrors;
	int otherErrors;
	int ackCount;
	int pixelsChecked;
	int seed;
	logic sourceOn;
	logic quietPhase;
	logic rasterStable;
	logic starveOk;
	logic [15:0] nextPixel;
	logic [15:0] expPixel;
	// pixels accepted by the buffer in arrival order
	logic [15:0] scoreboard [$];
	// raster geometry bookkeeping
	int deRun;
	int hsRun;
	int vsRun;
	int sinceDe;
	int activeLines;
	logic lineDe;
	logic prevDe;
	logic prevHs;
	logic prevVs;

	videoPostProcess videoPostProcess_i
	(
		.iVCLK(iVCLK),               .iVRST(iVRST),
		.i_pixelData(i_pixelData),   .i_pixelValid(i_pixelValid),
		.o_pixelFull(o_pixelFull),
		.i_wbCyc(i_wbCyc),           .i_wbStb(i_wbStb),
		.i_wbWe(i_wbWe),             .i_wbAdr(i_wbAdr),
		.i_wbDatW(i_wbDatW),         .o_wbDatR(o_wbDatR),
		.o_wbAck(o_wbAck),
		.o_videoHs(o_videoHs),       .o_videoVs(o_videoVs),
		.o_videoDe(o_videoDe),       .o_videoData(o_videoData)
	);

	// 40 ns period
	always #20 iVCLK = ~iVCLK;

	task automatic reportMismatch(input string testName, input int expected, input int actual);
		valueErrors++;
		$display("error %s: expected %0d, actual %0d", testName, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		otherErrors++;
		$display("%s", what);
	endtask

	task automatic checkValue(input string testName, input int expected, input int actual);
		assert (expected == actual)
		else reportMismatch(testName, expected, actual);
	endtask

	function automatic logic [15:0] byteSwap(input logic [15:0] p);
		return {p[7:0], p[15:8]};
	endfunction

	task automatic waitClocks(input int n);
		repeat (n) @(posedge iVCLK);
	endtask

	// ------------------------------
	// wishbone master
	// ------------------------------
	task automatic busAccess(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int n;
		int acksBefore;
		acksBefore = ackCount;
		rdat = '0;
		n = 0;
		@(posedge iVCLK);
		#2;
		i_wbCyc  = 1'b1;
		i_wbStb  = 1'b1;
		i_wbWe   = we;
		i_wbAdr  = adr;
		i_wbDatW = wdat;
		@(negedge iVCLK);
		while (!o_wbAck && n < cPollLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (o_wbAck)
			rdat = o_wbDatR;
		else
			reportFailure("timeout waiting for the wishbone ack");
		@(posedge iVCLK);
		#2;
		i_wbCyc = 1'b0;
		i_wbStb = 1'b0;
		i_wbWe  = 1'b0;
		@(negedge iVCLK);
		@(posedge iVCLK);
		assert (ackCount == acksBefore + 1)
		else reportFailure("a wishbone access did not get exactly one ack");
	endtask

	task automatic busWrite(input logic [1:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		busAccess(1'b1, adr, wdat, unused);
	endtask

	task automatic busRead(input logic [1:0] adr, output logic [31:0] rdat);
		busAccess(1'b0, adr, 32'd0, rdat);
	endtask

	// next rising data-enable
	task automatic waitDeRise();
		int n;
		n = 0;
		while (o_videoDe && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		while (!o_videoDe && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (!o_videoDe)
			reportFailure("timeout waiting for data-enable");
	endtask

	task automatic waitPixels(input int count);
		int n;
		int mark;
		n = 0;
		mark = pixelsChecked + count;
		while (pixelsChecked < mark && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (pixelsChecked < mark)
			reportFailure("timeout waiting for pixels at the display");
	endtask

	// ------------------------------
	// pixel source
	// ------------------------------
	always @(posedge iVCLK)
	begin
		#2;
		// random gaps leave about one clock in eight idle
		if (sourceOn && !o_pixelFull && (($random(seed) & 7) != 0))
		begin
			i_pixelValid = 1'b1;
			i_pixelData  = nextPixel;
		end
		else
			i_pixelValid = 1'b0;
	end

	// accepted write at the coming edge
	always @(negedge iVCLK)
	begin
		if (!iVRST && i_pixelValid && !o_pixelFull)
		begin
			scoreboard.push_back(i_pixelData);
			nextPixel++;
		end
	end

	always @(negedge iVCLK)
	begin
		if (o_wbAck)
			ackCount++;
	end

	// zero data is allowed only while the source is starved
	always @(negedge iVCLK)
	begin
		if (!iVRST && o_videoDe)
		begin
			if (o_videoData == 16'd0)
			begin
				assert (starveOk)
				else reportFailure("zero pixel shown while the source was not starved");
			end
			else if (scoreboard.size() == 0)
				reportFailure("pixel shown with no input pixel queued");
			else
			begin
				expPixel = byteSwap(scoreboard.pop_front());
				checkValue("pixel", int'(expPixel), int'(o_videoData));
				pixelsChecked++;
			end
		end
	end

	// ------------------------------
	// raster geometry
	// ------------------------------
	always @(negedge iVCLK)
	begin
		if (iVRST || !rasterStable)
		begin
			deRun       = 0;
			hsRun       = 0;
			vsRun       = 0;
			sinceDe     = 0;
			activeLines = 0;
			lineDe      = 1'b0;
			prevDe      = 1'b0;
			prevHs      = 1'b0;
			prevVs      = 1'b0;
		end
		else
		begin
			// edge checks come first while the counters still hold the earlier clocks
			if (prevDe && !o_videoDe)
			begin
				checkValue("deWidth", videoPkg::cHActive, deRun);
				activeLines++;
			end
			if (!prevHs && o_videoHs && lineDe)
			begin
				checkValue("hFront", videoPkg::cHFront, sinceDe);
				lineDe = 1'b0;
			end
			if (prevHs && !o_videoHs)
				checkValue("hsWidth", videoPkg::cHSync, hsRun);
			if (!prevVs && o_videoVs)
			begin
				checkValue("activeLines", videoPkg::cVActive, activeLines);
				activeLines = 0;
			end
			if (prevVs && !o_videoVs)
				checkValue("vsWidth", videoPkg::cVSync * videoPkg::cHTotal, vsRun);
			deRun   = o_videoDe ? deRun + 1 : 0;
			sinceDe = o_videoDe ? 0 : sinceDe + 1;
			hsRun   = o_videoHs ? hsRun + 1 : 0;
			vsRun   = o_videoVs ? vsRun + 1 : 0;
			if (o_videoDe)
				lineDe = 1'b1;
			prevDe = o_videoDe;
			prevHs = o_videoHs;
			prevVs = o_videoVs;
		end
	end

	// blanking, quiet start and ack shape
	assert property (@(negedge iVCLK) disable iff (iVRST) !o_videoDe |-> o_videoData == 16'd0)
	else reportMismatch("blankData", 0, int'(o_videoData));
	assert property (@(negedge iVCLK) disable iff (iVRST)
		quietPhase |-> !(o_videoDe || o_videoHs || o_videoVs))
	else reportFailure("raster output moved before the buffer was prefilled");
	assert property (@(negedge iVCLK) disable iff (iVRST) o_wbAck |-> !$past(o_wbAck))
	else reportFailure("wishbone ack lasted more than one clock");
	assert property (@(negedge iVCLK) disable iff (iVRST)
		o_wbAck |-> $past(i_wbCyc && i_wbStb))
	else reportFailure("wishbone ack without a request");

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		logic [31:0] rd;
		int n;
		seed          = 32'haab7;
		valueErrors   = 0;
		otherErrors   = 0;
		ackCount      = 0;
		pixelsChecked = 0;
		sourceOn      = 1'b0;
		quietPhase    = 1'b1;
		rasterStable  = 1'b0;
		starveOk      = 1'b0;
		nextPixel     = 16'h0001;
		iVCLK         = 1'b0;
		iVRST         = 1'b1;
		i_pixelData   = '0;
		i_pixelValid  = 1'b0;
		i_wbCyc       = 1'b0;
		i_wbStb       = 1'b0;
		i_wbWe        = 1'b0;
		i_wbAdr       = '0;
		i_wbDatW      = '0;
		waitClocks(8);
		#2;
		iVRST = 1'b0;

		// idle and then fill with the source still off
		busRead(videoPkg::cAdrStatus, rd);
		checkValue("statusIdle", 0, int'(rd));
		busRead(videoPkg::cAdrLevel, rd);
		checkValue("levelReset", 0, int'(rd));
		busWrite(videoPkg::cAdrCtrl, 32'd1);
		busRead(videoPkg::cAdrCtrl, rd);
		checkValue("ctrlReadback", 1, int'(rd));
		busRead(videoPkg::cAdrStatus, rd);
		checkValue("statusFill", 2, int'(rd));
		waitClocks(20);
		quietPhase   = 1'b0;
		rasterStable = 1'b1;
		sourceOn     = 1'b1;

		// source outruns the display until the buffer is full
		n = 0;
		while (!o_pixelFull && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (!o_pixelFull)
			reportFailure("timeout waiting for the buffer to fill up");
		// no fetches from the vsync rise until the next frame
		while (o_videoVs && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		while (!o_videoVs && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (!o_videoVs)
			reportFailure("timeout waiting for vsync");
		// the back porch after the vsync fall has no fetches either
		while (o_videoVs && n < cWaitLimit)
		begin
			@(negedge iVCLK);
			n++;
		end
		if (o_videoVs)
			reportFailure("timeout waiting for the end of vsync");
		checkValue("pixelFull", 1, int'(o_pixelFull));
		busRead(videoPkg::cAdrLevel, rd);
		checkValue("levelFull", videoPkg::cFifoDepth, int'(rd));
		busRead(videoPkg::cAdrStatus, rd);
		checkValue("statusFull", 12, int'(rd));

		// enable clear flushes the buffer
		sourceOn     = 1'b0;
		rasterStable = 1'b0;
		waitClocks(2);
		busWrite(videoPkg::cAdrCtrl, 32'd0);
		busRead(videoPkg::cAdrLevel, rd);
		checkValue("levelFlushed", 0, int'(rd));
		scoreboard.delete();

		// ------------------------------
		// starvation and restart
		// ------------------------------
		busWrite(videoPkg::cAdrCtrl, 32'd1);
		sourceOn = 1'b1;
		waitDeRise();
		waitPixels(20);
		starveOk = 1'b1;
		sourceOn = 1'b0;
		rd = '0;
		n = 0;
		while (rd[0] == 1'b0 && n < cPollLimit)
		begin
			busRead(videoPkg::cAdrStatus, rd);
			n++;
		end
		if (rd[0] == 1'b0)
			reportFailure("timeout waiting for the underflow flag");
		// flag is set and the FSM is back in stFill
		checkValue("statusUnder", 3, int'(rd));
		sourceOn = 1'b1;
		waitDeRise();
		waitPixels(16);
		starveOk = 1'b0;
		busRead(videoPkg::cAdrStatus, rd);
		checkValue("stickyFlag", 1, int'(rd[0]));
		busWrite(videoPkg::cAdrStatus, 32'd1);
		busRead(videoPkg::cAdrStatus, rd);
		checkValue("flagCleared", 4, int'(rd[2:0]));

		sourceOn = 1'b0;
		waitClocks(4);
		$display("errors: %0d value, %0d other, %0d pixels checked",
			valueErrors, otherErrors, pixelsChecked);
		if (valueErrors + otherErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- files.f
videoPkg.sv
pixelFifo.sv
videoTimingGen.sv
videoStartCtrl.sv
videoOutFormat.sv
videoWbRegs.sv
videoPostProcess.sv
videoPostProcessTb.sv

//--- run.sh
#!/bin/sh
# build and run the video output stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module videoPostProcessTb -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation run returned an error status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0
